/* Makefile */
TOOL  = verilator
FLAGS = --timing --assert
TOP   = neoled_tb
FLIST = vlog.f

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* rtl/neoled.sv */
// top level with plain host port; only addr_i[2] is decoded, FIFO_DEPTH power of two 1..32768
`default_nettype none
`include "neoled_settings.svh"

module neoled #(
    parameter int FIFO_DEPTH = `NEOLED_FIFO_DEPTH
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic [31:0] addr_i,
    input  logic        rden_i,
    input  logic        wren_i,
    input  logic [31:0] data_i,
    output logic [31:0] data_o,
    output logic        ack_o,
    output logic        clkgen_en_o,  // external prescaler on
    input  logic [7:0]  clkgen_i,     // prescaler taps
    output logic        irq_o,
    output logic        neoled_o      // serial pixel line
);
    neoled_cfg_if  u_cfg ();
    neoled_fifo_if u_fifo ();

    neoled_regs #(.FIFO_DEPTH(FIFO_DEPTH)) i_regs (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .addr_i     (addr_i),
        .rden_i     (rden_i),
        .wren_i     (wren_i),
        .data_i     (data_i),
        .data_o     (data_o),
        .ack_o      (ack_o),
        .irq_o      (irq_o),
        .clkgen_en_o(clkgen_en_o),
        .cfg        (u_cfg.regs),
        .fifo       (u_fifo.writer)
    );

    neoled_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .fifo  (u_fifo.store)
    );

    neoled_serial_tx i_serial (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .clkgen_i(clkgen_i),
        .neoled_o(neoled_o),
        .cfg     (u_cfg.engine),
        .fifo    (u_fifo.reader)
    );

endmodule

`default_nettype wire

/* rtl/neoled_if.sv */
// internal links between register block, tx FIFO and serial engine; not meant for the top ports
`default_nettype none

// ----------------------------------------
// control fields out, engine status back
interface neoled_cfg_if;
    neoled_pkg::ctrl_t ctrl;        // live control register
    logic              busy;        // engine not in IDLE

    modport regs (
        output ctrl,
        input  busy
    );
    modport engine (
        input  ctrl,
        output busy
    );
endinterface

// ----------------------------------------
// FWFT buffer between host writes and engine
interface neoled_fifo_if;
    logic                    we;    // push, dropped when full
    logic                    re;    // pop head
    logic                    clear; // sync flush
    neoled_pkg::fifo_entry_t wdata;
    neoled_pkg::fifo_entry_t rdata; // always the head entry
    logic                    avail; // not empty
    logic                    free;  // not full
    logic                    half;  // at least half full

    modport writer (output we, wdata, clear, input free, half, avail);
    modport reader (output re, input rdata, avail);
    modport store  (input we, re, clear, wdata, output rdata, avail, free, half);
endinterface

`default_nettype wire

/* rtl/neoled_pkg.sv */
// shared types of the transmitter; field widths come from the settings header
`default_nettype none
`include "neoled_settings.svh"

package neoled_pkg;

    // ----------------------------------------
    // writable control fields
    typedef struct packed {
        logic                      enable;    // off also flushes the fifo
        logic                      mode;      // 0 rgb 24 bit, 1 rgbw 32 bit
        logic                      strobe;    // tag for following data writes
        logic [`NEOLED_PRSC_W-1:0] prescaler; // clkgen_i bit used as tick
        logic                      irq_conf;  // 0 irq on empty, 1 on below half
        logic [`NEOLED_TIME_W-1:0] t_total;   // period is t_total+1 ticks
        logic [`NEOLED_TIME_W-1:0] t0_high;
        logic [`NEOLED_TIME_W-1:0] t1_high;
    } ctrl_t;

    // ----------------------------------------
    // one pixel word, bytes listed in wire order
    typedef union packed {
        struct packed {
            logic [7:0] pad;                  // ignored in rgb mode
            logic [7:0] c0;                   // first byte out
            logic [7:0] c1;
            logic [7:0] c2;
        } rgb;
        struct packed {
            logic [7:0] c0;                   // first byte out
            logic [7:0] c1;
            logic [7:0] c2;
            logic [7:0] c3;
        } rgbw;
    } led_word_u;

    typedef struct packed {
        logic      strobe;                    // send reset gap instead of data
        logic      mode;                      // word length of this entry
        led_word_u word;
    } fifo_entry_t;

    typedef enum logic [2:0] {IDLE, INIT, GETBIT, PULSE, STROBE} serial_state_e;

endpackage

`default_nettype wire

/* rtl/neoled_regs.sv */
// only addr_i[2] is decoded (0 control, 1 data); writes to a full FIFO are dropped silently
`default_nettype none
`include "neoled_settings.svh"

module neoled_regs #(
    parameter int FIFO_DEPTH = `NEOLED_FIFO_DEPTH  // power of two, 1..32768
) (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic [31:0]   addr_i,
    input  logic          rden_i,
    input  logic          wren_i,
    input  logic [31:0]   data_i,
    output logic [31:0]   data_o,
    output logic          ack_o,
    output logic          irq_o,
    output logic          clkgen_en_o,
    neoled_cfg_if.regs    cfg,
    neoled_fifo_if.writer fifo
);
    localparam int BUFS_W = `NEOLED_CTRL_TTOT_LSB - `NEOLED_CTRL_BUFS_LSB;
    localparam logic [BUFS_W-1:0] DEPTH_LOG2 = BUFS_W'($clog2(FIFO_DEPTH));
    localparam logic IRQ_CONF_TIE = (FIFO_DEPTH == 1);  // single entry has no half level

    logic        ctrl_sel;  // word offset 0
    logic        irq_conf;  // effective irq condition
    logic [31:0] rd_word;   // control/status image

    assign ctrl_sel = ~addr_i[2];
    assign irq_conf = cfg.ctrl.irq_conf | IRQ_CONF_TIE;

    // control register ----------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg.ctrl <= '0;
        end else if (wren_i && ctrl_sel) begin
            cfg.ctrl.enable    <= data_i[`NEOLED_CTRL_EN];
            cfg.ctrl.mode      <= data_i[`NEOLED_CTRL_MODE];
            cfg.ctrl.strobe    <= data_i[`NEOLED_CTRL_STROBE];
            cfg.ctrl.prescaler <= data_i[`NEOLED_CTRL_PRSC_LSB +: `NEOLED_PRSC_W];
            cfg.ctrl.irq_conf  <= data_i[`NEOLED_CTRL_IRQ_CONF];
            cfg.ctrl.t_total   <= data_i[`NEOLED_CTRL_TTOT_LSB +: `NEOLED_TIME_W];
            cfg.ctrl.t0_high   <= data_i[`NEOLED_CTRL_T0H_LSB +: `NEOLED_TIME_W];
            cfg.ctrl.t1_high   <= data_i[`NEOLED_CTRL_T1H_LSB +: `NEOLED_TIME_W];
        end
    end

    // readback image
    always_comb begin
        rd_word                                                = '0;
        rd_word[`NEOLED_CTRL_EN]                               = cfg.ctrl.enable;
        rd_word[`NEOLED_CTRL_MODE]                             = cfg.ctrl.mode;
        rd_word[`NEOLED_CTRL_STROBE]                           = cfg.ctrl.strobe;
        rd_word[`NEOLED_CTRL_PRSC_LSB +: `NEOLED_PRSC_W]       = cfg.ctrl.prescaler;
        rd_word[`NEOLED_CTRL_BUFS_LSB +: BUFS_W]               = DEPTH_LOG2;
        rd_word[`NEOLED_CTRL_TTOT_LSB +: `NEOLED_TIME_W]       = cfg.ctrl.t_total;
        rd_word[`NEOLED_CTRL_T0H_LSB +: `NEOLED_TIME_W]        = cfg.ctrl.t0_high;
        rd_word[`NEOLED_CTRL_T1H_LSB +: `NEOLED_TIME_W]        = cfg.ctrl.t1_high;
        rd_word[`NEOLED_CTRL_IRQ_CONF]                         = irq_conf;
        rd_word[`NEOLED_CTRL_EMPTY]                            = ~fifo.avail;
        rd_word[`NEOLED_CTRL_HALF]                             = fifo.half;
        rd_word[`NEOLED_CTRL_FULL]                             = ~fifo.free;
        rd_word[`NEOLED_CTRL_BUSY]                             = cfg.busy;
    end

    // bus response and interrupt -------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_o  <= 1'b0;
            data_o <= '0;
            irq_o  <= 1'b0;
        end else begin
            ack_o  <= wren_i | rden_i;                         // one cycle after any access
            data_o <= (rden_i && ctrl_sel) ? rd_word : '0;     // data offset reads as zero
            irq_o  <= cfg.ctrl.enable & (irq_conf ? ~fifo.half : ~fifo.avail);
        end
    end

    // FIFO side
    assign fifo.we     = wren_i & addr_i[2];
    assign fifo.wdata  = {cfg.ctrl.strobe, cfg.ctrl.mode, data_i};  // tag with current mode
    assign fifo.clear  = ~cfg.ctrl.enable;                          // flush while disabled
    assign clkgen_en_o = cfg.ctrl.enable;

endmodule

`default_nettype wire

/* rtl/neoled_serial_tx.sv */
// serial engine; tick is clkgen_i[prescaler] sampled one cycle late, timing fields apply live
`default_nettype none
`include "neoled_settings.svh"

module neoled_serial_tx (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic [7:0]    clkgen_i,
    output logic          neoled_o,
    neoled_cfg_if.engine  cfg,
    neoled_fifo_if.reader fifo
);
    localparam int CNT_W = $clog2(`NEOLED_BITS_RGBW + 1);

    neoled_pkg::serial_state_e   state;
    neoled_pkg::fifo_entry_t     entry_q;     // popped head
    neoled_pkg::led_word_u       sreg;        // shifts left, msb first
    logic [CNT_W-1:0]            bit_cnt;     // bits still to send
    logic [`NEOLED_TIME_W-1:0]   t_high;      // high ticks of current bit
    logic [`NEOLED_TIME_W-1:0]   pulse_cnt;
    logic [`NEOLED_STROBE_W-1:0] strobe_cnt;  // low periods in a strobe
    logic                        tick;
    logic                        tx_out;
    logic                        tx_q;        // output stage
    logic                        next_bit;

    // msb of the active view, bit 23 or bit 31
    assign next_bit = entry_q.mode ? sreg.rgbw.c0[7] : sreg.rgb.c0[7];

    // ----------------------------------------
    // state machine
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state      <= neoled_pkg::IDLE;
            tick       <= 1'b0;
            tx_out     <= 1'b0;
            tx_q       <= 1'b0;
            pulse_cnt  <= '0;
            strobe_cnt <= '0;
        end else begin
            tick <= clkgen_i[cfg.ctrl.prescaler];           // one cycle late
            tx_q <= tx_out;
            if (!cfg.ctrl.enable) begin
                state  <= neoled_pkg::IDLE;
                tx_out <= 1'b0;
            end else begin
                case (state)
                    neoled_pkg::IDLE: begin
                        tx_out     <= 1'b0;
                        pulse_cnt  <= '0;
                        strobe_cnt <= '0;
                        if (fifo.avail) state <= neoled_pkg::INIT;  // pop this edge
                    end
                    neoled_pkg::INIT: begin
                        state <= entry_q.strobe ? neoled_pkg::STROBE : neoled_pkg::GETBIT;
                    end
                    neoled_pkg::GETBIT: begin
                        pulse_cnt <= '0;
                        if (bit_cnt == '0) begin            // word done
                            tx_out <= 1'b0;
                            state  <= neoled_pkg::IDLE;
                        end else begin
                            tx_out <= 1'b1;                 // every bit starts high
                            state  <= neoled_pkg::PULSE;
                        end
                    end
                    neoled_pkg::PULSE: begin
                        if (tick) begin
                            pulse_cnt <= pulse_cnt + 1'b1;
                            if (pulse_cnt == t_high) tx_out <= 1'b0;
                            if (pulse_cnt == cfg.ctrl.t_total) state <= neoled_pkg::GETBIT;
                        end
                    end
                    neoled_pkg::STROBE: begin
                        if (tick) begin
                            if (pulse_cnt == cfg.ctrl.t_total) begin
                                pulse_cnt  <= '0;
                                strobe_cnt <= strobe_cnt + 1'b1;
                            end else begin
                                pulse_cnt <= pulse_cnt + 1'b1;
                            end
                        end
                        if (&strobe_cnt) state <= neoled_pkg::IDLE;  // 127 periods
                    end
                    default: state <= neoled_pkg::IDLE;
                endcase
            end
        end
    end

    // ----------------------------------------
    // datapath
    always_ff @(posedge clk_i) begin
        if (fifo.re) entry_q <= fifo.rdata;
        case (state)
            neoled_pkg::INIT: begin
                sreg    <= entry_q.word;
                bit_cnt <= entry_q.mode ? CNT_W'(`NEOLED_BITS_RGBW) : CNT_W'(`NEOLED_BITS_RGB);
            end
            neoled_pkg::GETBIT: begin
                sreg    <= {sreg[30:0], 1'b0};
                bit_cnt <= bit_cnt - 1'b1;
                t_high  <= next_bit ? cfg.ctrl.t1_high : cfg.ctrl.t0_high;
            end
            default: begin
            end
        endcase
    end

    assign fifo.re  = (state == neoled_pkg::IDLE) & fifo.avail & cfg.ctrl.enable;
    assign cfg.busy = (state != neoled_pkg::IDLE);
    assign neoled_o = tx_q & cfg.ctrl.enable;               // forced low once disabled

endmodule

`default_nettype wire

/* rtl/neoled_settings.svh */
// register layout is fixed to one 32-bit control word and FIFO depth must be a power of two 1..32768
`ifndef NEOLED_SETTINGS_SVH
`define NEOLED_SETTINGS_SVH

// ----------------------------------------
`define NEOLED_FIFO_DEPTH    4      // default tx buffer entries

// control word bit positions
`define NEOLED_CTRL_EN       0      // module enable
`define NEOLED_CTRL_MODE     1      // 0 rgb, 1 rgbw
`define NEOLED_CTRL_STROBE   2      // data writes become strobes
`define NEOLED_CTRL_PRSC_LSB 3      // clkgen tap select
`define NEOLED_CTRL_BUFS_LSB 6      // log2 depth, read only
`define NEOLED_CTRL_TTOT_LSB 10     // ticks per bit period
`define NEOLED_CTRL_T0H_LSB  15     // high ticks for a zero
`define NEOLED_CTRL_T1H_LSB  20     // high ticks for a one
`define NEOLED_CTRL_IRQ_CONF 27     // irq condition select
`define NEOLED_CTRL_EMPTY    28     // status bits from here up
`define NEOLED_CTRL_HALF     29
`define NEOLED_CTRL_FULL     30
`define NEOLED_CTRL_BUSY     31

// ----------------------------------------
`define NEOLED_PRSC_W        3      // selects one of 8 clkgen_i taps
`define NEOLED_TIME_W        5      // timing fields
`define NEOLED_BITS_RGB      24
`define NEOLED_BITS_RGBW     32
`define NEOLED_STROBE_W      7      // strobe ends at all ones, 127 periods

`endif

/* rtl/neoled_tx_fifo.sv */
// first-word-fall-through buffer; FIFO_DEPTH must be a power of two 1..32768, writes when full are lost
`default_nettype none
`include "neoled_settings.svh"

module neoled_tx_fifo #(
    parameter int FIFO_DEPTH = `NEOLED_FIFO_DEPTH
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    neoled_fifo_if.store fifo
);
    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int IW = (AW > 0) ? AW : 1;              // index width, min 1
    localparam int PW = AW + 1;                         // extra wrap bit
    localparam logic [PW-1:0] DEPTH_P = PW'(FIFO_DEPTH);
    localparam logic [PW:0]   DEPTH_H = (PW + 1)'(FIFO_DEPTH);

    neoled_pkg::fifo_entry_t mem [FIFO_DEPTH];
    logic [PW-1:0] wptr;
    logic [PW-1:0] rptr;
    logic [PW-1:0] level;                               // entries held
    logic [IW-1:0] widx;
    logic [IW-1:0] ridx;
    logic          do_wr;
    logic          do_rd;

    assign level      = wptr - rptr;
    assign fifo.avail = (level != '0);
    assign fifo.free  = (level != DEPTH_P);
    assign fifo.half  = ({level, 1'b0} >= DEPTH_H);     // 2*level >= depth
    assign do_wr      = fifo.we & fifo.free;
    assign do_rd      = fifo.re & fifo.avail;
    assign widx       = (AW > 0) ? wptr[IW-1:0] : '0;
    assign ridx       = (AW > 0) ? rptr[IW-1:0] : '0;

    // pointers ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wptr <= '0;
            rptr <= '0;
        end else if (fifo.clear) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_wr) wptr <= wptr + 1'b1;
            if (do_rd) rptr <= rptr + 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_wr) mem[widx] <= fifo.wdata;
    end

    assign fifo.rdata = mem[ridx];                      // head shows without a read

endmodule

`default_nettype wire

/* verification/neoled_sva.sv */
// bound into neoled_serial_tx; checks are off while rstn_i is low
`default_nettype none

module neoled_sva (
    input logic                      clk_i,
    input logic                      rstn_i,
    input logic                      tx_line_i,  // engine line before the output stage
    input logic                      enable_i,
    input logic                      busy_i,
    input neoled_pkg::serial_state_e state_i,
    input logic                      re_i        // fifo pop
);

    // ----------------------------------------
    a_line_low_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !enable_i |=> !tx_line_i)
        else $error("engine line still high a cycle after enable went low");

    // busy ends at a word end, a strobe end or a disable
    a_busy_via_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $fell(busy_i) |-> (!$past(enable_i) ||
                           ($past(state_i) == neoled_pkg::GETBIT) ||
                           ($past(state_i) == neoled_pkg::STROBE)))
        else $error("busy dropped outside a word end or a disable");

    a_init_after_pop: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_i == neoled_pkg::INIT) |-> $past(re_i))
        else $error("INIT entered without a FIFO pop");

endmodule

`default_nettype wire

/* verification/neoled_tb.sv */
// directed testbench at default depth 4; bit timing fixed at t_total 9, t0_high 2, t1_high 6
`default_nettype none
`include "neoled_settings.svh"

module neoled_tb;
    localparam int          DRIVE_DLY = 2;          // after rising edge
    localparam logic [31:0] CTRL_ADDR = 32'h0;
    localparam logic [31:0] DATA_ADDR = 32'h4;      // addr_i[2] set
    localparam logic [4:0]  TT        = 5'd9;       // t_total
    localparam logic [4:0]  T0H       = 5'd2;
    localparam logic [4:0]  T1H       = 5'd6;
    localparam int STROBE_CYC = 127 * (TT + 1);
    localparam int MAX_POLL   = STROBE_CYC + 200;   // longest busy phase plus slack
    localparam int WATCHDOG_CYC = 4 + (24 + 32) * (TT + 2) + STROBE_CYC + 1000;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic [31:0] addr_i;
    logic        rden_i;
    logic        wren_i;
    logic [31:0] data_i;
    logic [7:0]  clkgen_i;
    logic [31:0] data_o;
    logic        ack_o;
    logic        clkgen_en_o;
    logic        irq_o;
    logic        neoled_o;

    int          val_errs;
    int          misc_errs;
    logic [31:0] lcg_state;
    logic        pulse_bits[$];                     // decoded line bits, oldest first
    int          hi_cnt;

    neoled i_dut (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .addr_i     (addr_i),
        .rden_i     (rden_i),
        .wren_i     (wren_i),
        .data_i     (data_i),
        .data_o     (data_o),
        .ack_o      (ack_o),
        .clkgen_en_o(clkgen_en_o),
        .clkgen_i   (clkgen_i),
        .irq_o      (irq_o),
        .neoled_o   (neoled_o)
    );

    bind neoled_serial_tx neoled_sva i_sva (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .tx_line_i(tx_out),
        .enable_i (cfg.ctrl.enable),
        .busy_i   (cfg.busy),
        .state_i  (state),
        .re_i     (fifo.re)
    );

    always #20 clk_i = ~clk_i;                      // period 40

    // ----------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // control word as laid out in the register map
    function automatic logic [31:0] ctrl_word(input logic en, input logic mode,
                                              input logic strobe,
                                              input logic [`NEOLED_PRSC_W-1:0] prsc,
                                              input logic irq_conf, input logic [4:0] ttot,
                                              input logic [4:0] t0h, input logic [4:0] t1h);
        logic [31:0] w;
        w                                               = '0;
        w[`NEOLED_CTRL_EN]                              = en;
        w[`NEOLED_CTRL_MODE]                            = mode;
        w[`NEOLED_CTRL_STROBE]                          = strobe;
        w[`NEOLED_CTRL_PRSC_LSB +: `NEOLED_PRSC_W]      = prsc;
        w[`NEOLED_CTRL_TTOT_LSB +: `NEOLED_TIME_W]      = ttot;
        w[`NEOLED_CTRL_T0H_LSB +: `NEOLED_TIME_W]       = t0h;
        w[`NEOLED_CTRL_T1H_LSB +: `NEOLED_TIME_W]       = t1h;
        w[`NEOLED_CTRL_IRQ_CONF]                        = irq_conf;
        return w;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        val_errs++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    endtask

    // one-cycle strobes, ack expected right after the sampling edge
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input string name);
        addr_i = addr;
        data_i = data;
        wren_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY;
        wren_i = 1'b0;
        if (ack_o !== 1'b1) begin
            misc_errs++;
            $display("%s: no acknowledge after a write", name);
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, input string name,
                            output logic [31:0] data);
        addr_i = addr;
        rden_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY;
        rden_i = 1'b0;
        if (ack_o !== 1'b1) begin
            misc_errs++;
            $display("%s: no acknowledge after a read", name);
        end
        data = data_o;
    endtask

    // high time above midpoint of (t0_high+1) and (t1_high+1) is a one
    task automatic sample_line();
        if (neoled_o === 1'b1) begin
            hi_cnt++;
        end else if (hi_cnt > 0) begin
            pulse_bits.push_back(2 * hi_cnt > T0H + T1H + 2);
            hi_cnt = 0;
        end
    endtask

    always @(negedge clk_i) sample_line();          // line settled mid cycle

    // polls status every cycle, counts busy cycles until busy drops
    task automatic wait_word_done(input string name, output int busy_cyc,
                                  output bit line_seen_high);
        logic [31:0] st;
        int          n;
        busy_cyc       = 0;
        line_seen_high = 1'b0;
        n              = 0;
        do begin
            bus_read(CTRL_ADDR, name, st);
            n++;
        end while (!st[`NEOLED_CTRL_BUSY] && n < 8);
        if (!st[`NEOLED_CTRL_BUSY]) begin
            misc_errs++;
            $display("%s: engine never became busy", name);
        end else begin
            while (st[`NEOLED_CTRL_BUSY] && n < MAX_POLL) begin
                busy_cyc++;
                if (neoled_o === 1'b1) line_seen_high = 1'b1;
                bus_read(CTRL_ADDR, name, st);
                n++;
            end
            if (st[`NEOLED_CTRL_BUSY]) begin
                misc_errs++;
                $display("%s: busy did not clear in time", name);
            end
        end
    endtask

    // ----------------------------------------
    task automatic test_register_readback();
        logic [31:0] wr;
        logic [31:0] exp;
        logic [31:0] rd;
        wr  = ctrl_word(1'b1, 1'b1, 1'b0, 3'd5, 1'b1, 5'd21, 5'd7, 5'd14);
        exp = wr | (32'd2 << `NEOLED_CTRL_BUFS_LSB) | (32'd1 << `NEOLED_CTRL_EMPTY);
        if (ack_o !== 1'b0) begin
            misc_errs++;
            $display("readback: acknowledge high with the bus idle");
        end
        bus_write(CTRL_ADDR, wr, "readback");
        @(posedge clk_i);
        #DRIVE_DLY;
        if (ack_o !== 1'b0) begin
            misc_errs++;
            $display("readback: acknowledge longer than one cycle");
        end
        bus_read(CTRL_ADDR, "readback", rd);
        if (rd !== exp) report_value("readback", exp, rd);
        // enabled, irq on below half, FIFO empty
        if (irq_o !== 1'b1) report_value("readback irq", 32'd1, {31'd0, irq_o});
        if (clkgen_en_o !== 1'b1) begin
            report_value("readback clkgen_en", 32'd1, {31'd0, clkgen_en_o});
        end
    endtask

    task automatic test_transfer(input logic mode, input string name);
        logic [31:0] word;
        logic [31:0] exp;
        logic [31:0] rx;
        int          nbits;
        int          busy_cyc;
        bit          seen_high;
        nbits = mode ? `NEOLED_BITS_RGBW : `NEOLED_BITS_RGB;
        bus_write(CTRL_ADDR, ctrl_word(1'b1, mode, 1'b0, 3'd0, 1'b0, TT, T0H, T1H), name);
        word = lcg_next();
        exp  = mode ? word : {8'h00, word[23:0]};   // pad byte never sent
        pulse_bits.delete();
        bus_write(DATA_ADDR, word, name);
        wait_word_done(name, busy_cyc, seen_high);
        if (pulse_bits.size() != nbits) begin
            report_value({name, " pulse count"}, nbits, pulse_bits.size());
        end else begin
            rx = '0;
            foreach (pulse_bits[i]) rx = {rx[30:0], pulse_bits[i]};
            if (rx !== exp) report_value(name, exp, rx);
        end
    endtask

    task automatic test_fifo_levels();
        logic [31:0] st;
        clkgen_i = 8'h00;                           // no ticks, engine stalls
        bus_write(CTRL_ADDR, ctrl_word(1'b1, 1'b0, 1'b0, 3'd0, 1'b0, TT, T0H, T1H), "fifo");
        repeat (5) bus_write(DATA_ADDR, lcg_next(), "fifo");  // one held by engine
        bus_read(CTRL_ADDR, "fifo", st);
        if (st[31:28] !== 4'b1110) report_value("fifo status full", 32'he, {28'd0, st[31:28]});
        if (irq_o !== 1'b0) report_value("fifo irq full", 32'd0, {31'd0, irq_o});
        bus_write(CTRL_ADDR, ctrl_word(1'b0, 1'b0, 1'b0, 3'd0, 1'b0, TT, T0H, T1H), "fifo");
        @(posedge clk_i);                           // flush lands a cycle later
        #DRIVE_DLY;
        bus_read(CTRL_ADDR, "fifo", st);
        if (st[31:28] !== 4'b0001) report_value("fifo status off", 32'h1, {28'd0, st[31:28]});
        if (irq_o !== 1'b0) report_value("fifo irq off", 32'd0, {31'd0, irq_o});
        if (clkgen_en_o !== 1'b0) begin
            report_value("fifo clkgen_en off", 32'd0, {31'd0, clkgen_en_o});
        end
        clkgen_i = 8'hff;
    endtask

    task automatic test_strobe();
        int busy_cyc;
        bit seen_high;
        bus_write(CTRL_ADDR, ctrl_word(1'b1, 1'b0, 1'b1, 3'd0, 1'b0, TT, T0H, T1H), "strobe");
        bus_write(DATA_ADDR, lcg_next(), "strobe");
        wait_word_done("strobe", busy_cyc, seen_high);
        if (seen_high) begin
            misc_errs++;
            $display("strobe: serial line went high during the reset gap");
        end
        if (busy_cyc < STROBE_CYC) report_value("strobe busy cycles", STROBE_CYC, busy_cyc);
    endtask

    // ----------------------------------------
    initial begin
        rstn_i    = 1'b0;
        addr_i    = '0;
        rden_i    = 1'b0;
        wren_i    = 1'b0;
        data_i    = '0;
        clkgen_i  = 8'hff;                          // tick every cycle
        lcg_state = 32'h5c7e_a2b0;
        val_errs  = 0;
        misc_errs = 0;
        hi_cnt    = 0;
        repeat (4) @(posedge clk_i);
        #DRIVE_DLY;
        rstn_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY;
        test_register_readback();
        test_transfer(1'b0, "rgb");
        test_transfer(1'b1, "rgbw");
        test_fifo_levels();
        test_strobe();
        $display("errors: %0d wrong values, %0d other failures", val_errs, misc_errs);
        if (val_errs + misc_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // bounded by the summed worst-case transfer and strobe lengths
    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/neoled_pkg.sv
rtl/neoled_if.sv
rtl/neoled_regs.sv
rtl/neoled_tx_fifo.sv
rtl/neoled_serial_tx.sv
rtl/neoled.sv
verification/neoled_sva.sv
verification/neoled_tb.sv
